//--- all.f
+incdir+hdl
hdl/assocProcPkg.sv
hdl/cellArray.sv
hdl/tagMatcher.sv
hdl/apSequencer.sv
hdl/assocProcTop.sv
dv/clockGen.sv
dv/assocProcTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module assocProcTb -f all.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

simOut=$(./obj_dir/simv)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Pass message not found"
exit 1

//--- dv/assocProcTb.sv
`timescale 1ns/1ps
`include "assocProc_defines.svh"

module assocProcTb;

  typedef logic [`AP_WB_ADR_WIDTH-1:0] adrT;
  typedef logic [`AP_WB_DAT_WIDTH-1:0] datT;

  localparam int AckTimeout = 20; // Cycles to wait for ack

  logic clk;
  logic rstIn;
  assocProcPkg::wbReqT wbReq;
  logic wbAck;
  datT wbDatOut;

  // Reference model state
  assocProcPkg::rowWordT model [`AP_DATA_DEPTH];
  assocProcPkg::colWordT modelTag;
  assocProcPkg::rowWordT modelKey;
  assocProcPkg::rowWordT modelMask;
  logic [31:0] lcgState;

  clockGen #(.PeriodNs(40)) u_clk
  (
    .clk (clk)
  );

  assocProcTop u_dut
  (
    .clk      (clk),
    .rstIn    (rstIn),
    .wbReq    (wbReq),
    .wbAck    (wbAck),
    .wbDatOut (wbDatOut)
  );

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic assocProcPkg::rowWordT randWord();
    logic [31:0] v;
    v = nextRand();
    return v[23:16]; // Upper bits have the longer period
  endfunction

  // Row matches when every masked bit equals the key bit
  function automatic assocProcPkg::colWordT searchRef();
    assocProcPkg::colWordT t;
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      t[r] = 1'b1;
      for (int c = 0; c < `AP_DATA_WIDTH; c++)
      begin
        if (modelMask[c] && (model[r][c] != modelKey[c]))
          t[r] = 1'b0;
      end
    end
    return t;
  endfunction

  function automatic assocProcPkg::rowWordT tagWriteRef(input assocProcPkg::rowWordT old);
    assocProcPkg::rowWordT res;
    for (int c = 0; c < `AP_DATA_WIDTH; c++)
    begin
      res[c] = modelMask[c] ? modelKey[c] : old[c];
    end
    return res;
  endfunction

  function automatic assocProcPkg::rowWordT complementRef(input assocProcPkg::rowWordT old,
                                                         input logic absOpt);
    if (absOpt && !old[`AP_DATA_WIDTH-1])
      return old; // Positive row left alone
    return old ^ modelMask;
  endfunction

  function automatic assocProcPkg::colWordT colSliceRef(input int c);
    assocProcPkg::colWordT s;
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      s[r] = model[r][c];
    end
    return s;
  endfunction

  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic checkRow(input string name, input assocProcPkg::rowWordT expected,
                          input assocProcPkg::rowWordT actual);
    if (actual !== expected)
      reportFailure($sformatf("error %s expected 0x%h actual 0x%h", name, expected, actual));
  endtask

  task automatic checkCol(input string name, input assocProcPkg::colWordT expected,
                          input assocProcPkg::colWordT actual);
    if (actual !== expected)
      reportFailure($sformatf("error %s expected 0x%h actual 0x%h", name, expected, actual));
  endtask

  task automatic checkTag(input assocProcPkg::colWordT expected,
                          input assocProcPkg::colWordT actual);
    if (actual !== expected)
      reportFailure($sformatf("error tag expected 0x%h actual 0x%h", expected, actual));
  endtask

  // One classic cycle, request held until ack
  task automatic busCycle(input logic we, input adrT adr, input datT dat, output datT rdat);
    int waitCount;
    @(negedge clk);
    wbReq.cyc = 1'b1;
    wbReq.stb = 1'b1;
    wbReq.we  = we;
    wbReq.adr = adr;
    wbReq.dat = dat;
    waitCount = 0;
    while (!wbAck)
    begin
      if (waitCount == AckTimeout)
        reportFailure("no acknowledge from the bus");
      @(negedge clk);
      waitCount++;
    end
    rdat = wbDatOut;
    wbReq.cyc = 1'b0;
    wbReq.stb = 1'b0;
    wbReq.we  = 1'b0;
  endtask

  task automatic wbWrite(input adrT adr, input datT dat);
    datT unused;
    busCycle(1'b1, adr, dat, unused);
  endtask

  task automatic wbRead(input adrT adr, output datT dat);
    busCycle(1'b0, adr, '0, dat);
  endtask

  task automatic checkAllRows();
    datT d;
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      wbRead(adrT'(`AP_ROW_BASE + r), d);
      checkRow($sformatf("row%0d", r), model[r], assocProcPkg::rowWordT'(d));
    end
  endtask

  task automatic checkAllCols();
    datT d;
    for (int c = 0; c < `AP_DATA_WIDTH; c++)
    begin
      wbRead(adrT'(`AP_COL_BASE + c), d);
      checkCol($sformatf("col%0d", c), colSliceRef(c), assocProcPkg::colWordT'(d));
    end
  endtask

  task automatic setKeyMask(input assocProcPkg::rowWordT key, input assocProcPkg::rowWordT mask);
    datT d;
    wbWrite(`AP_REG_KEY, datT'(key));
    wbWrite(`AP_REG_MASK, datT'(mask));
    modelKey  = key;
    modelMask = mask;
    wbRead(`AP_REG_KEY, d);
    checkRow("key", modelKey, assocProcPkg::rowWordT'(d));
    wbRead(`AP_REG_MASK, d);
    checkRow("mask", modelMask, assocProcPkg::rowWordT'(d));
  endtask

  task automatic runSearch();
    datT d;
    wbWrite(`AP_REG_SEARCH, '0);
    modelTag = searchRef();
    wbRead(`AP_REG_TAG, d);
    checkTag(modelTag, assocProcPkg::colWordT'(d));
  endtask

  task automatic tagComplement(input logic absOpt);
    wbWrite(`AP_REG_TAGCPL, datT'(absOpt));
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      if (modelTag[r])
        model[r] = complementRef(model[r], absOpt);
    end
    checkAllRows();
  endtask

  initial
  begin
    assocProcPkg::colWordT cv;
    datT d;
    lcgState  = 32'd42123;
    rstIn     = 1'b0;
    wbReq     = '0;
    modelTag  = '0;
    modelKey  = '0;
    modelMask = '0;
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
      model[r] = '0;
    repeat (8) @(negedge clk);
    rstIn = 1'b1;

    // Reset state
    checkAllRows();
    wbRead(`AP_REG_TAG, d);
    checkTag(modelTag, assocProcPkg::colWordT'(d));
    wbRead(`AP_REG_KEY, d);
    checkRow("key", modelKey, assocProcPkg::rowWordT'(d));
    wbRead(`AP_REG_MASK, d);
    checkRow("mask", modelMask, assocProcPkg::rowWordT'(d));
    runSearch(); // Zero mask over zero rows tags everything

    // Row writes, read back by row and by column
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      model[r] = randWord();
      wbWrite(adrT'(`AP_ROW_BASE + r), datT'(model[r]));
    end
    checkAllRows();
    checkAllCols();

    // Column writes land transposed
    for (int c = 0; c < `AP_DATA_WIDTH; c++)
    begin
      cv = randWord();
      wbWrite(adrT'(`AP_COL_BASE + c), datT'(cv));
      for (int r = 0; r < `AP_DATA_DEPTH; r++)
        model[r][c] = cv[r];
    end
    checkAllRows();
    checkAllCols();

    // Searches, keys taken from stored rows so that some match
    for (int i = 0; i < 6; i++)
    begin
      setKeyMask(model[nextRand() % `AP_DATA_DEPTH] ^ (randWord() & 8'h11), randWord());
      runSearch();
    end
    setKeyMask(randWord(), '0);
    runSearch();

    // Tagged writes with a fresh key after the search
    for (int i = 0; i < 3; i++)
    begin
      setKeyMask(model[nextRand() % `AP_DATA_DEPTH], randWord() & 8'h0f);
      runSearch();
      setKeyMask(randWord(), randWord());
      wbWrite(`AP_REG_TAGWR, '0);
      for (int r = 0; r < `AP_DATA_DEPTH; r++)
      begin
        if (modelTag[r])
          model[r] = tagWriteRef(model[r]);
      end
      checkAllRows();
    end

    // Complement without and with the absolute option
    setKeyMask(model[nextRand() % `AP_DATA_DEPTH], randWord() & 8'h3c);
    runSearch();
    setKeyMask(randWord(), randWord());
    tagComplement(1'b0);
    // One row of each sign for the absolute option
    model[0] = randWord() & 8'h7f;
    model[1] = randWord() | 8'h80;
    wbWrite(adrT'(`AP_ROW_BASE), datT'(model[0]));
    wbWrite(adrT'(`AP_ROW_BASE + 1), datT'(model[1]));
    setKeyMask(randWord(), '0);
    runSearch();
    setKeyMask(randWord(), 8'h7f | randWord());
    tagComplement(1'b1);
    checkAllCols();

    $display("Everything OK");
    $finish;
  end

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ps

module clockGen
#(
  parameter int PeriodNs = 40
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  always
  begin
    #(PeriodNs / 2) clk = ~clk;
  end

endmodule

//--- hdl/assocProcTop.sv
`timescale 1ns/1ps
`include "assocProc_defines.svh"

module assocProcTop
(
  input  logic                        clk,
  input  logic                        rstIn,
  input  assocProcPkg::wbReqT         wbReq,
  output logic                        wbAck,
  output logic [`AP_WB_DAT_WIDTH-1:0] wbDatOut
);

  assocProcPkg::apCmdT   cmd;
  assocProcPkg::rowAddrT rdRow;
  assocProcPkg::colAddrT rdCol;
  assocProcPkg::rowWordT rowOut;
  assocProcPkg::colWordT colOut;
  assocProcPkg::colWordT tag;
  assocProcPkg::arrayT   cells;

  apSequencer u_seq
  (
    .clk      (clk),
    .rstIn    (rstIn),
    .wbReq    (wbReq),
    .wbAck    (wbAck),
    .wbDatOut (wbDatOut),
    .cmd      (cmd),
    .rdRow    (rdRow),
    .rdCol    (rdCol),
    .rowOut   (rowOut),
    .colOut   (colOut),
    .tag      (tag)
  );

  // Search result feeds tagged ops
  tagMatcher u_match
  (
    .clk   (clk),
    .rstIn (rstIn),
    .cmd   (cmd),
    .cells (cells),
    .tag   (tag)
  );

  cellArray u_array
  (
    .clk    (clk),
    .rstIn  (rstIn),
    .cmd    (cmd),
    .tag    (tag),
    .rdRow  (rdRow),
    .rdCol  (rdCol),
    .rowOut (rowOut),
    .colOut (colOut),
    .cells  (cells)
  );

endmodule

//--- hdl/apSequencer.sv
`timescale 1ns/1ps
`include "assocProc_defines.svh"

module apSequencer
(
  input  logic                         clk,
  input  logic                         rstIn,
  input  assocProcPkg::wbReqT          wbReq,
  output logic                         wbAck,
  output logic [`AP_WB_DAT_WIDTH-1:0]  wbDatOut,
  output assocProcPkg::apCmdT          cmd,
  output assocProcPkg::rowAddrT        rdRow,
  output assocProcPkg::colAddrT        rdCol,
  input  assocProcPkg::rowWordT        rowOut,
  input  assocProcPkg::colWordT        colOut,
  input  assocProcPkg::colWordT        tag
);

  assocProcPkg::seqStateT state;
  assocProcPkg::apOpT op;
  assocProcPkg::rowWordT key;
  assocProcPkg::rowWordT mask;
  logic absOpt;

  logic [`AP_WB_ADR_WIDTH-1:0] reqAdr;
  logic [`AP_WB_DAT_WIDTH-1:0] reqDat;
  logic [`AP_WB_DAT_WIDTH-1:0] rdMux;
  logic reqWe;
  logic isRow;
  logic isCol;

  assign isRow = (reqAdr >= `AP_ROW_BASE) && (reqAdr < `AP_ROW_BASE + `AP_DATA_DEPTH);
  assign isCol = (reqAdr >= `AP_COL_BASE) && (reqAdr < `AP_COL_BASE + `AP_DATA_WIDTH);

  // Operation only in S_EXEC
  always_comb
  begin
    op = assocProcPkg::OP_NONE;
    if (state == assocProcPkg::S_EXEC && reqWe)
    begin
      if (isRow)
        op = assocProcPkg::OP_ROW_WR;
      else if (isCol)
        op = assocProcPkg::OP_COL_WR;
      else if (reqAdr == `AP_REG_SEARCH)
        op = assocProcPkg::OP_SEARCH;
      else if (reqAdr == `AP_REG_TAGWR)
        op = assocProcPkg::OP_TAG_WR;
      else if (reqAdr == `AP_REG_TAGCPL)
        op = assocProcPkg::OP_TAG_CPL;
    end
  end

  assign cmd = '{op: op, rowAddr: rdRow, colAddr: rdCol,
                 wrRow: reqDat[`AP_DATA_WIDTH-1:0], wrCol: reqDat[`AP_DATA_DEPTH-1:0],
                 key: key, mask: mask, absOpt: absOpt};

  // Read data, zero-extended
  always_comb
  begin
    rdMux = '0;
    if (isRow)
      rdMux[`AP_DATA_WIDTH-1:0] = rowOut;
    else if (isCol)
      rdMux[`AP_DATA_DEPTH-1:0] = colOut;
    else if (reqAdr == `AP_REG_KEY)
      rdMux[`AP_DATA_WIDTH-1:0] = key;
    else if (reqAdr == `AP_REG_MASK)
      rdMux[`AP_DATA_WIDTH-1:0] = mask;
    else if (reqAdr == `AP_REG_TAG)
      rdMux[`AP_DATA_DEPTH-1:0] = tag;
  end

  always_ff @(posedge clk)
  begin
    if (state == assocProcPkg::S_IDLE)
    begin
      reqAdr <= wbReq.adr;
      reqDat <= wbReq.dat;
      reqWe  <= wbReq.we;
      rdRow  <= assocProcPkg::rowAddrT'(wbReq.adr);
      rdCol  <= assocProcPkg::colAddrT'(wbReq.adr);
    end
    if (state == assocProcPkg::S_EXEC)
      wbDatOut <= rdMux; // Stable through S_ACK
  end

  always_ff @(posedge clk)
  begin
    if (!rstIn)
    begin
      state  <= assocProcPkg::S_IDLE;
      wbAck  <= 1'b0;
      key    <= '0;
      mask   <= '0;
      absOpt <= 1'b0;
    end
    else
    begin
      wbAck <= (state == assocProcPkg::S_EXEC); // One cycle only
      case (state)
        assocProcPkg::S_IDLE:
        begin
          if (wbReq.cyc && wbReq.stb)
          begin
            state <= assocProcPkg::S_EXEC;
            if (wbReq.we && wbReq.adr == `AP_REG_TAGCPL)
              absOpt <= wbReq.dat[0];
          end
        end
        assocProcPkg::S_EXEC:
        begin
          state <= assocProcPkg::S_ACK;
          if (reqWe && reqAdr == `AP_REG_KEY)
            key <= reqDat[`AP_DATA_WIDTH-1:0];
          if (reqWe && reqAdr == `AP_REG_MASK)
            mask <= reqDat[`AP_DATA_WIDTH-1:0];
        end
        default:
        begin
          // Wait for master to drop strobe
          if (!wbReq.stb)
            state <= assocProcPkg::S_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hdl/tagMatcher.sv
`timescale 1ns/1ps
`include "assocProc_defines.svh"

module tagMatcher
(
  input  logic                  clk,
  input  logic                  rstIn,
  input  assocProcPkg::apCmdT   cmd,
  input  assocProcPkg::arrayT   cells,
  output assocProcPkg::colWordT tag
);

  assocProcPkg::colWordT hit;
  assocProcPkg::rowWordT row;

  // Masked compare, all-zero mask matches every row
  always_comb
  begin
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      row    = cells[r*`AP_DATA_WIDTH +: `AP_DATA_WIDTH];
      hit[r] = ((row ^ cmd.key) & cmd.mask) == '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstIn)
    begin
      tag <= '0;
    end
    else if (cmd.op == assocProcPkg::OP_SEARCH)
    begin
      tag <= hit; // Held until next search
    end
  end

endmodule

//--- hdl/cellArray.sv
`timescale 1ns/1ps
`include "assocProc_defines.svh"

module cellArray
(
  input  logic                  clk,
  input  logic                  rstIn,
  input  assocProcPkg::apCmdT   cmd,
  input  assocProcPkg::colWordT tag,
  input  assocProcPkg::rowAddrT rdRow,
  input  assocProcPkg::colAddrT rdCol,
  output assocProcPkg::rowWordT rowOut,
  output assocProcPkg::colWordT colOut,
  output assocProcPkg::arrayT   cells
);

  assocProcPkg::rowWordT cellQ [`AP_DATA_DEPTH];
  assocProcPkg::rowWordT cellD [`AP_DATA_DEPTH];
  assocProcPkg::rowWordT bitEn [`AP_DATA_DEPTH];
  assocProcPkg::rowWordT bitVal [`AP_DATA_DEPTH];

  assocProcPkg::colWordT rowSel;
  assocProcPkg::rowWordT colSel;
  assocProcPkg::colWordT signOk;
  logic tagWr;
  logic tagCpl;

  assign tagWr  = (cmd.op == assocProcPkg::OP_TAG_WR);
  assign tagCpl = (cmd.op == assocProcPkg::OP_TAG_CPL);

  // Row and column selects
  always_comb
  begin
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      rowSel[r] = (cmd.op == assocProcPkg::OP_ROW_WR) &&
                  (cmd.rowAddr == assocProcPkg::rowAddrT'(r));
      // Absolute option limits complement to negative rows
      signOk[r] = !cmd.absOpt || cellQ[r][`AP_DATA_WIDTH-1];
    end
    for (int c = 0; c < `AP_DATA_WIDTH; c++)
    begin
      colSel[c] = (cmd.op == assocProcPkg::OP_COL_WR) &&
                  (cmd.colAddr == assocProcPkg::colAddrT'(c));
    end
  end

  // Per-bit enable and value
  always_comb
  begin
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      for (int c = 0; c < `AP_DATA_WIDTH; c++)
      begin
        if (rowSel[r] || colSel[c])
        begin
          bitEn[r][c]  = 1'b1;
          bitVal[r][c] = rowSel[r] ? cmd.wrRow[c] : cmd.wrCol[r]; // Column bit k goes to row k
        end
        else
        begin
          bitEn[r][c]  = tag[r] & cmd.mask[c] & (tagWr | (tagCpl & signOk[r]));
          bitVal[r][c] = tagWr ? cmd.key[c] : ~cellQ[r][c];
        end
      end
    end
  end

  always_comb
  begin
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      cellD[r] = (bitEn[r] & bitVal[r]) | (~bitEn[r] & cellQ[r]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstIn)
    begin
      cellQ <= '{default: '0};
    end
    else
    begin
      cellQ <= cellD;
    end
  end

  // Reads straight from stored cells
  always_comb
  begin
    rowOut = cellQ[rdRow];
    for (int r = 0; r < `AP_DATA_DEPTH; r++)
    begin
      colOut[r] = cellQ[r][rdCol];
      cells[r*`AP_DATA_WIDTH +: `AP_DATA_WIDTH] = cellQ[r];
    end
  end

endmodule

//--- hdl/assocProcPkg.sv
`include "assocProc_defines.svh"

package assocProcPkg;

  typedef logic [`AP_DATA_WIDTH-1:0] rowWordT;
  typedef logic [`AP_DATA_DEPTH-1:0] colWordT; // Column slice or tag vector
  typedef logic [$clog2(`AP_DATA_DEPTH)-1:0] rowAddrT;
  typedef logic [$clog2(`AP_DATA_WIDTH)-1:0] colAddrT;

  // Row r sits in slice r
  typedef logic [`AP_DATA_DEPTH*`AP_DATA_WIDTH-1:0] arrayT;

  typedef enum logic [2:0]
  {
    OP_NONE,
    OP_ROW_WR,
    OP_COL_WR,
    OP_TAG_WR,
    OP_TAG_CPL,
    OP_SEARCH
  } apOpT;

  typedef struct packed
  {
    apOpT    op;
    rowAddrT rowAddr;
    colAddrT colAddr;
    rowWordT wrRow;
    colWordT wrCol;
    rowWordT key;
    rowWordT mask;
    logic    absOpt;
  } apCmdT;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_ACK} seqStateT;

  // Master to slave half of the bus
  typedef struct packed
  {
    logic cyc;
    logic stb;
    logic we;
    logic [`AP_WB_ADR_WIDTH-1:0] adr;
    logic [`AP_WB_DAT_WIDTH-1:0] dat;
  } wbReqT;

endpackage

//--- hdl/assocProc_defines.svh
`ifndef ASSOCPROC_DEFINES_SVH
`define ASSOCPROC_DEFINES_SVH

// Array geometry, columns equal the row word width
`define AP_DATA_WIDTH 8
`define AP_DATA_DEPTH 8

// Wishbone widths
`define AP_WB_ADR_WIDTH 6
`define AP_WB_DAT_WIDTH 16

// Register map
`define AP_REG_KEY    6'h00
`define AP_REG_MASK   6'h01
`define AP_REG_SEARCH 6'h02
`define AP_REG_TAGWR  6'h03
`define AP_REG_TAGCPL 6'h04 // Bit 0 of data is the absolute option
`define AP_REG_TAG    6'h05
`define AP_ROW_BASE   6'h10
`define AP_COL_BASE   6'h20

`endif
